// ==== hdl/alu.sv ====
// Unsigned carry is a borrow on subtraction, overflow only reflects add and subtract forms
`timescale 1ns/1ps
`default_nettype none
`include "cpu_macros.svh"

module alu (
    input  wire                         CLK,
    input  wire                         rstN_i,
    input  datapathPkg::ctrlWord_t      ctrl_i,
    input  wire [`CPU_DATA_WIDTH-1:0]   opA_i,
    input  wire [`CPU_DATA_WIDTH-1:0]   opB_i,
    output logic [`CPU_DATA_WIDTH-1:0]  result_o,
    output datapathPkg::aluFlags_t      flags_o
);

    localparam int Msb = `CPU_DATA_WIDTH - 1;

    logic carry;
    logic overflow;

    always_comb begin
        carry    = 1'b0;
        overflow = 1'b0;
        case (ctrl_i.aluOp)
            datapathPkg::NOT_A: result_o = ~opA_i;
            datapathPkg::AND:   result_o = opA_i & opB_i;
            datapathPkg::OR:    result_o = opA_i | opB_i;
            datapathPkg::ADD: begin
                {carry, result_o} = {1'b0, opA_i} + {1'b0, opB_i};
                overflow = (opA_i[Msb] == opB_i[Msb]) && (result_o[Msb] != opA_i[Msb]);
            end
            datapathPkg::SUB: begin
                {carry, result_o} = {1'b0, opA_i} - {1'b0, opB_i};  // Top bit is the borrow
                overflow = (opA_i[Msb] != opB_i[Msb]) && (result_o[Msb] != opA_i[Msb]);
            end
            datapathPkg::INC: begin
                {carry, result_o} = {1'b0, opA_i} + 1'b1;
                overflow = !opA_i[Msb] && result_o[Msb];
            end
            datapathPkg::DEC: begin
                {carry, result_o} = {1'b0, opA_i} - 1'b1;
                overflow = opA_i[Msb] && !result_o[Msb];
            end
            datapathPkg::SHR: begin
                result_o = opA_i >> 1;
                carry    = opA_i[0];
            end
            datapathPkg::SHL: begin
                result_o = opA_i << 1;
                carry    = opA_i[Msb];
            end
            default: result_o = opA_i;  // PASS_A
        endcase
    end

    always_ff @(posedge CLK or negedge rstN_i) begin
        if (!rstN_i) begin
            flags_o <= '0;
        end else if (ctrl_i.flagsEn) begin
            flags_o.zero     <= (result_o == '0);
            flags_o.carry    <= carry;
            flags_o.negative <= result_o[Msb];
            flags_o.overflow <= overflow;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/controlFsm.sv ====
// Fixed three-cycle sequence per instruction, memory must answer reads in the same cycle
`timescale 1ns/1ps
`default_nettype none
`include "cpu_macros.svh"

module controlFsm (
    input  wire                         CLK,
    input  wire                         rstN_i,
    input  wire [`CPU_DATA_WIDTH-1:0]   memRdData_i,
    input  datapathPkg::aluFlags_t      flags_i,
    input  wire [`CPU_DATA_WIDTH-1:0]   pc_i,
    output datapathPkg::ctrlWord_t      ctrl_o,
    output logic [`CPU_DATA_WIDTH-1:0]  imm_o,
    output logic                        pcInc_o,
    output logic                        pcLoad_o,
    output logic [`CPU_DATA_WIDTH-1:0]  pcTarget_o,
    output logic [`CPU_DATA_WIDTH-1:0]  memAddr_o,
    output logic                        memWr_o
);

    typedef enum logic [1:0] {
        FETCH_HI,
        FETCH_LO,
        EXECUTE
    } state_e;

    state_e                  state;
    isaPkg::instrWord_u      irWord;
    datapathPkg::aluOp_e     aluSel;

    always_ff @(posedge CLK or negedge rstN_i) begin
        if (!rstN_i) begin
            state <= FETCH_HI;
        end else begin
            case (state)
                FETCH_HI: state <= FETCH_LO;
                FETCH_LO: state <= EXECUTE;
                default:  state <= FETCH_HI;
            endcase
        end
    end

    // Instruction register, loaded one byte per fetch cycle
    always_ff @(posedge CLK) begin
        if (state == FETCH_HI) begin
            irWord[`CPU_INSTR_WIDTH-1 -: `CPU_DATA_WIDTH] <= memRdData_i;
        end else if (state == FETCH_LO) begin
            irWord[`CPU_DATA_WIDTH-1:0] <= memRdData_i;
        end
    end

    always_comb begin
        case (irWord.regForm.opcode)
            isaPkg::NOT: aluSel = datapathPkg::NOT_A;
            isaPkg::AND: aluSel = datapathPkg::AND;
            isaPkg::OR:  aluSel = datapathPkg::OR;
            isaPkg::ADD: aluSel = datapathPkg::ADD;
            isaPkg::SUB: aluSel = datapathPkg::SUB;
            isaPkg::LSR: aluSel = datapathPkg::SHR;  // Right shift
            isaPkg::LSL: aluSel = datapathPkg::SHL;
            isaPkg::INC: aluSel = datapathPkg::INC;
            isaPkg::DEC: aluSel = datapathPkg::DEC;
            default:     aluSel = datapathPkg::PASS_A;  // MOV
        endcase
    end

    always_comb begin
        ctrl_o   = '0;
        pcLoad_o = 1'b0;
        memWr_o  = 1'b0;
        if (state == EXECUTE) begin
            case (irWord.regForm.opcode)
                isaPkg::BRA: pcLoad_o = 1'b1;
                isaPkg::BNE: pcLoad_o = !flags_i.zero;
                isaPkg::LD: begin
                    ctrl_o.rfWrEn  = 1'b1;
                    ctrl_o.rfWrIdx = irWord.addrForm.regIdx;
                    ctrl_o.rfWrSrc = irWord.addrForm.addrMode ? datapathPkg::IMM
                                                              : datapathPkg::MEM;
                end
                isaPkg::ST: begin
                    memWr_o         = 1'b1;
                    ctrl_o.rfRdBIdx = irWord.addrForm.regIdx;
                end
                isaPkg::MOV, isaPkg::AND, isaPkg::OR, isaPkg::NOT, isaPkg::ADD,
                isaPkg::SUB, isaPkg::LSR, isaPkg::LSL, isaPkg::INC, isaPkg::DEC: begin
                    ctrl_o.aluOp    = aluSel;
                    ctrl_o.rfRdAIdx = isaPkg::regIndex(irWord.regForm.src1);
                    ctrl_o.rfRdBIdx = isaPkg::regIndex(irWord.regForm.src2);
                    ctrl_o.rfWrIdx  = isaPkg::regIndex(irWord.regForm.dest);
                    ctrl_o.rfWrEn   = isaPkg::isGenReg(irWord.regForm.dest);
                    ctrl_o.flagsEn  = 1'b1;
                end
                default: ;  // Opcodes B and C
            endcase
        end
    end

    assign pcInc_o    = (state != EXECUTE);
    assign imm_o      = irWord.addrForm.operand;
    assign pcTarget_o = irWord.addrForm.operand;
    assign memAddr_o  = (state == EXECUTE) ? irWord.addrForm.operand : pc_i;

    // A store goes to a fully fetched operand address
    memWrAddrKnown: assert property (@(posedge CLK) disable iff (!rstN_i)
        memWr_o |-> !$isunknown(memAddr_o));

endmodule

`default_nettype wire

// ==== hdl/cpuTop.sv ====
// CPU core with an external byte RAM that must answer reads combinationally
`timescale 1ns/1ps
`default_nettype none
`include "cpu_macros.svh"

module cpuTop (
    input  wire                         CLK,
    input  wire                         rstN_i,
    input  wire [`CPU_DATA_WIDTH-1:0]   memRdData_i,
    output logic [`CPU_DATA_WIDTH-1:0]  memAddr_o,
    output logic                        memWr_o,
    output logic [`CPU_DATA_WIDTH-1:0]  memWrData_o
);

    datapathPkg::ctrlWord_t       ctrl;
    datapathPkg::aluFlags_t       flags;
    logic [`CPU_DATA_WIDTH-1:0]   imm;
    logic [`CPU_DATA_WIDTH-1:0]   pc;
    logic [`CPU_DATA_WIDTH-1:0]   pcTarget;
    logic                         pcInc;
    logic                         pcLoad;
    logic [`CPU_DATA_WIDTH-1:0]   opA;
    logic [`CPU_DATA_WIDTH-1:0]   opB;
    logic [`CPU_DATA_WIDTH-1:0]   aluResult;

    controlFsm uCtrl (
        .CLK(CLK), .rstN_i(rstN_i), .memRdData_i(memRdData_i), .flags_i(flags),
        .pc_i(pc), .ctrl_o(ctrl), .imm_o(imm), .pcInc_o(pcInc), .pcLoad_o(pcLoad),
        .pcTarget_o(pcTarget), .memAddr_o(memAddr_o), .memWr_o(memWr_o)
    );

    programCounter uPc (
        .CLK(CLK), .rstN_i(rstN_i), .inc_i(pcInc), .load_i(pcLoad),
        .target_i(pcTarget), .pc_o(pc)
    );

    registerFile uRegs (
        .CLK(CLK), .rstN_i(rstN_i), .ctrl_i(ctrl), .imm_i(imm), .memRdData_i(memRdData_i),
        .aluResult_i(aluResult), .opA_o(opA), .opB_o(opB)
    );

    alu uAlu (
        .CLK(CLK), .rstN_i(rstN_i), .ctrl_i(ctrl), .opA_i(opA), .opB_i(opB),
        .result_o(aluResult), .flags_o(flags)
    );

    assign memWrData_o = opB;  // Store data from read port B

endmodule

`default_nettype wire

// ==== hdl/datapathPkg.sv ====
// Datapath types; the control word carries no memory strobe, that travels on its own port
`default_nettype none
`include "cpu_macros.svh"

package datapathPkg;

    typedef enum logic [3:0] {
        PASS_A,
        NOT_A,
        ADD,
        SUB,
        AND,
        OR,
        SHR,
        SHL,
        INC,
        DEC
    } aluOp_e;

    typedef struct packed {
        logic zero;
        logic carry;     // Borrow on SUB and DEC
        logic negative;
        logic overflow;
    } aluFlags_t;

    typedef enum logic [1:0] {
        ALU,
        IMM,
        MEM
    } wrSrc_e;

    typedef struct packed {
        logic                            rfWrEn;
        logic [`CPU_REG_IDX_WIDTH-1:0]   rfWrIdx;
        wrSrc_e                          rfWrSrc;
        logic [`CPU_REG_IDX_WIDTH-1:0]   rfRdAIdx;
        logic [`CPU_REG_IDX_WIDTH-1:0]   rfRdBIdx;  // Also the store data source
        aluOp_e                          aluOp;
        logic                            flagsEn;
    } ctrlWord_t;

endpackage

`default_nettype wire

// ==== hdl/isaPkg.sv ====
// Instruction set types; opcodes B and C are not enumerated and execute as no-operations
`default_nettype none
`include "cpu_macros.svh"

package isaPkg;

    typedef enum logic [3:0] {
        BRA = 4'h0,
        LD  = 4'h1,
        ST  = 4'h2,
        MOV = 4'h3,
        AND = 4'h4,
        OR  = 4'h5,
        NOT = 4'h6,
        ADD = 4'h7,
        SUB = 4'h8,
        LSR = 4'h9,
        LSL = 4'hA,
        INC = 4'hD,
        DEC = 4'hE,
        BNE = 4'hF
    } opcode_e;

    typedef logic [3:0] regCode_t;

    localparam regCode_t REG_R0 = 4'h4;  // Lowest general register code
    localparam regCode_t REG_R3 = 4'h7;

    typedef struct packed {
        opcode_e                         opcode;
        logic                            spare;
        logic                            addrMode;  // 1 means immediate
        logic [`CPU_REG_IDX_WIDTH-1:0]   regIdx;
        logic [`CPU_DATA_WIDTH-1:0]      operand;
    } addrForm_t;

    typedef struct packed {
        opcode_e  opcode;
        regCode_t dest;
        regCode_t src1;
        regCode_t src2;
    } regForm_t;

    typedef union packed {
        addrForm_t addrForm;  // BRA, LD, ST, BNE
        regForm_t  regForm;   // Register-to-register operations
    } instrWord_u;

    function automatic logic isGenReg(regCode_t code);
        return (code >= REG_R0) && (code <= REG_R3);
    endfunction

    // Codes outside R0..R3 read as R0
    function automatic logic [`CPU_REG_IDX_WIDTH-1:0] regIndex(regCode_t code);
        return isGenReg(code) ? code[`CPU_REG_IDX_WIDTH-1:0] : '0;
    endfunction

endpackage

`default_nettype wire

// ==== hdl/programCounter.sv ====
// Eight-bit PC that wraps at 255, load and increment must not be requested together
`timescale 1ns/1ps
`default_nettype none
`include "cpu_macros.svh"

module programCounter (
    input  wire                         CLK,
    input  wire                         rstN_i,
    input  wire                         inc_i,
    input  wire                         load_i,
    input  wire [`CPU_DATA_WIDTH-1:0]   target_i,
    output logic [`CPU_DATA_WIDTH-1:0]  pc_o
);

    always_ff @(posedge CLK or negedge rstN_i) begin
        if (!rstN_i) begin
            pc_o <= '0;
        end else if (load_i) begin
            pc_o <= target_i;  // Branch taken
        end else if (inc_i) begin
            pc_o <= pc_o + 1'b1;
        end
    end

    // Fetch cycles increment, only EXECUTE may load
    noIncWithLoad: assert property (@(posedge CLK) disable iff (!rstN_i)
        !(inc_i && load_i));

endmodule

`default_nettype wire

// ==== hdl/registerFile.sv ====
// Four general registers with combinational reads, a write shows up one cycle later
`timescale 1ns/1ps
`default_nettype none
`include "cpu_macros.svh"

module registerFile (
    input  wire                         CLK,
    input  wire                         rstN_i,
    input  datapathPkg::ctrlWord_t      ctrl_i,
    input  wire [`CPU_DATA_WIDTH-1:0]   imm_i,
    input  wire [`CPU_DATA_WIDTH-1:0]   memRdData_i,
    input  wire [`CPU_DATA_WIDTH-1:0]   aluResult_i,
    output logic [`CPU_DATA_WIDTH-1:0]  opA_o,
    output logic [`CPU_DATA_WIDTH-1:0]  opB_o
);

    logic [`CPU_DATA_WIDTH-1:0] regs [`CPU_NUM_REGS];
    logic [`CPU_DATA_WIDTH-1:0] wrData;

    always_comb begin
        case (ctrl_i.rfWrSrc)
            datapathPkg::IMM: wrData = imm_i;
            datapathPkg::MEM: wrData = memRdData_i;  // Direct load
            default:          wrData = aluResult_i;
        endcase
    end

    always_ff @(posedge CLK or negedge rstN_i) begin
        if (!rstN_i) begin
            for (int i = 0; i < `CPU_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (ctrl_i.rfWrEn) begin
            regs[ctrl_i.rfWrIdx] <= wrData;
        end
    end

    assign opA_o = regs[ctrl_i.rfRdAIdx];
    assign opB_o = regs[ctrl_i.rfRdBIdx];

    // A write never takes an undefined source
    wrSrcLegal: assert property (@(posedge CLK) disable iff (!rstN_i)
        ctrl_i.rfWrEn |-> ctrl_i.rfWrSrc inside {datapathPkg::ALU, datapathPkg::IMM,
                                                 datapathPkg::MEM});

endmodule

`default_nettype wire

// ==== include/cpu_macros.svh ====
// Widths assume an 8-bit data path with 16-bit instructions, changing one alone is unsupported
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// Data bytes and memory addresses share one width
`define CPU_DATA_WIDTH 8

// Instruction fetched as two data-width bytes
`define CPU_INSTR_WIDTH 16

// General registers R0 to R3
`define CPU_NUM_REGS 4

// Index into the register file
`define CPU_REG_IDX_WIDTH 2

`endif

// ==== sim/cpuTb.sv ====
// RAM model answers reads in the same cycle, every test program ends in a branch to itself
`timescale 1ns/1ps
`default_nettype none
`include "cpu_macros.svh"

module cpuTb;

    typedef logic [`CPU_DATA_WIDTH-1:0] dataByte_t;

    typedef struct packed {
        dataByte_t addr;
        dataByte_t data;
    } memWrite_t;

    localparam int NumInstr      = 1 + 11 + 2 * 23 + 4 + 9 + 7;  // Halt fetches included
    localparam int NumRuns       = 7;
    localparam int TimeoutCycles = 3 * NumInstr + 20 * NumRuns;

    logic      CLK;
    logic      rstN;
    logic      memWr;
    dataByte_t memAddr;
    dataByte_t memRdData;
    dataByte_t memWrData;
    dataByte_t ram [2**`CPU_DATA_WIDTH];
    memWrite_t writeQ [$];
    memWrite_t expWrQ [$];
    dataByte_t fetchQ [$];
    dataByte_t expFetchQ [$];
    dataByte_t progPc;
    dataByte_t haltAddr;
    int        cyc;
    int        totalCyc    = 0;
    int        dataErrors  = 0;
    int        addrErrors  = 0;
    int        otherErrors = 0;

    isaPkg::opcode_e aluOps [10] = '{isaPkg::MOV, isaPkg::AND, isaPkg::OR, isaPkg::NOT,
        isaPkg::ADD, isaPkg::SUB, isaPkg::LSR, isaPkg::LSL, isaPkg::INC, isaPkg::DEC};

    tbClock clkGen (.CLK(CLK));

    cpuTop dut_i (
        .CLK(CLK), .rstN_i(rstN), .memRdData_i(memRdData), .memAddr_o(memAddr),
        .memWr_o(memWr), .memWrData_o(memWrData)
    );

    assign memRdData = ram[memAddr];  // Combinational read

    // FETCH_HI falls on every third cycle after reset release
    always @(posedge CLK) begin
        if (!rstN) begin
            cyc = 0;
            if (memWr !== 1'b0) begin
                $display("memWr_o was not low during reset at time %0d ns", $time);
                otherErrors++;
            end
        end else begin
            if (cyc % 3 == 0) begin
                fetchQ.push_back(memAddr);
            end
            if (memWr === 1'b1) begin
                writeQ.push_back({memAddr, memWrData});
                ram[memAddr] <= memWrData;
            end
            cyc++;
        end
    end

    always @(posedge CLK) begin
        totalCyc++;
        if (totalCyc > TimeoutCycles) begin
            $display("Timeout after %0d cycles, a program never reached its halt", totalCyc);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    function automatic logic [`CPU_INSTR_WIDTH-1:0] addrInstr(isaPkg::opcode_e op,
            logic imm, logic [`CPU_REG_IDX_WIDTH-1:0] idx, dataByte_t operand);
        isaPkg::instrWord_u w;
        w.addrForm.opcode   = op;
        w.addrForm.spare    = 1'b0;
        w.addrForm.addrMode = imm;
        w.addrForm.regIdx   = idx;
        w.addrForm.operand  = operand;
        return w;
    endfunction

    // Register indices 0 to 3 map onto codes R0 to R3
    function automatic logic [`CPU_INSTR_WIDTH-1:0] regInstr(isaPkg::opcode_e op,
            logic [1:0] dest, logic [1:0] src1, logic [1:0] src2);
        isaPkg::instrWord_u w;
        w.regForm.opcode = op;
        w.regForm.dest   = isaPkg::REG_R0 + dest;
        w.regForm.src1   = isaPkg::REG_R0 + src1;
        w.regForm.src2   = isaPkg::REG_R0 + src2;
        return w;
    endfunction

    function automatic dataByte_t expAlu(isaPkg::opcode_e op, dataByte_t a, dataByte_t b);
        case (op)
            isaPkg::AND: return a & b;
            isaPkg::OR:  return a | b;
            isaPkg::NOT: return ~a;
            isaPkg::ADD: return a + b;
            isaPkg::SUB: return a - b;
            isaPkg::LSR: return a >> 1;
            isaPkg::LSL: return a << 1;
            isaPkg::INC: return a + 1;
            isaPkg::DEC: return a - 1;
            default:     return a;  // MOV
        endcase
    endfunction

    task automatic checkByte(dataByte_t got, dataByte_t exp, string what);
        if (got !== exp) begin
            $display("ERROR at %0d ns: %s is %h, expected %h", $time, what, got, exp);
            dataErrors++;
        end
    endtask

    task automatic checkAddr(dataByte_t got, dataByte_t exp, string what);
        if (got !== exp) begin
            $display("ERROR at %0d ns: %s is %h, expected %h", $time, what, got, exp);
            addrErrors++;
        end
    endtask

    task automatic emit(logic [`CPU_INSTR_WIDTH-1:0] word);
        ram[progPc]     = word[`CPU_INSTR_WIDTH-1 -: `CPU_DATA_WIDTH];  // High byte first
        ram[progPc + 1] = word[`CPU_DATA_WIDTH-1:0];
        progPc += 2;
    endtask

    task automatic haltHere();
        haltAddr = progPc;
        emit(addrInstr(isaPkg::BRA, 1'b0, '0, progPc));
    endtask

    task automatic expectWrite(dataByte_t addr, dataByte_t data);
        expWrQ.push_back({addr, data});
    endtask

    task automatic expectStraight();
        for (int a = 0; a <= haltAddr; a += 2) begin
            expFetchQ.push_back(a);
        end
    endtask

    task automatic startTest();
        rstN = 1'b0;
        writeQ.delete();
        expWrQ.delete();
        fetchQ.delete();
        expFetchQ.delete();
        for (int i = 0; i < 2**`CPU_DATA_WIDTH; i++) begin
            ram[i] = dataByte_t'(i) ^ 8'h3C;
        end
        progPc = '0;
    endtask

    task automatic finishTest();
        repeat (2) @(posedge CLK);
        #1 rstN = 1'b1;
        while (fetchQ.size() == 0 || fetchQ[$] != haltAddr) begin
            @(posedge CLK);
            #1;
        end
        if (writeQ.size() != expWrQ.size()) begin
            $display("Saw %0d memory writes where %0d were expected", writeQ.size(),
                     expWrQ.size());
            otherErrors++;
        end else begin
            foreach (expWrQ[i]) begin
                checkByte(writeQ[i].addr, expWrQ[i].addr, $sformatf("write %0d address", i));
                checkByte(writeQ[i].data, expWrQ[i].data, $sformatf("write %0d data", i));
            end
        end
        if (fetchQ.size() != expFetchQ.size()) begin
            $display("Saw %0d instruction fetches where %0d were expected", fetchQ.size(),
                     expFetchQ.size());
            otherErrors++;
        end else begin
            foreach (expFetchQ[i]) begin
                checkAddr(fetchQ[i], expFetchQ[i], $sformatf("fetch %0d address", i));
            end
        end
    endtask

    task automatic resetTest();
        startTest();
        haltHere();
        expFetchQ.push_back('0);  // First fetch from address 0
        finishTest();
    endtask

    task automatic loadStoreTest();
        dataByte_t vals [`CPU_NUM_REGS];
        dataByte_t direct;
        startTest();
        for (int r = 0; r < `CPU_NUM_REGS; r++) begin
            vals[r] = $urandom % 256;
            emit(addrInstr(isaPkg::LD, 1'b1, r, vals[r]));
        end
        for (int r = 0; r < `CPU_NUM_REGS; r++) begin
            emit(addrInstr(isaPkg::ST, 1'b0, r, 8'h80 + r));
            expectWrite(8'h80 + r, vals[r]);
        end
        direct      = $urandom % 256;
        ram[8'hC0]  = direct;
        emit(addrInstr(isaPkg::LD, 1'b0, 2'd1, 8'hC0));  // Direct load into R1
        emit(addrInstr(isaPkg::ST, 1'b0, 2'd1, 8'h90));
        expectWrite(8'h90, direct);
        haltHere();
        expectStraight();
        finishTest();
    endtask

    task automatic aluTest();
        dataByte_t a;
        dataByte_t b;
        startTest();
        a = $urandom % 256;
        b = $urandom % 256;
        emit(addrInstr(isaPkg::LD, 1'b1, 2'd0, a));
        emit(addrInstr(isaPkg::LD, 1'b1, 2'd1, b));
        for (int k = 0; k < 10; k++) begin
            emit(regInstr(aluOps[k], 2'd2, 2'd0, 2'd1));  // R2 = R0 op R1
            emit(addrInstr(isaPkg::ST, 1'b0, 2'd2, 8'hA0 + k));
            expectWrite(8'hA0 + k, expAlu(aluOps[k], a, b));
        end
        haltHere();
        expectStraight();
        finishTest();
    endtask

    task automatic timingTest();
        startTest();
        emit({4'hB, 12'h000});
        emit({4'hC, 12'h000});
        emit(addrInstr(isaPkg::BRA, 1'b0, '0, 8'h40));
        progPc = 8'h40;
        haltHere();
        for (int a = 0; a <= 4; a += 2) begin
            expFetchQ.push_back(a);
        end
        expFetchQ.push_back(8'h40);  // Branch target
        finishTest();
    endtask

    task automatic bneTest();
        dataByte_t v;
        startTest();
        v = $urandom % 256;
        emit(addrInstr(isaPkg::LD, 1'b1, 2'd0, v));
        emit(addrInstr(isaPkg::LD, 1'b1, 2'd3, 8'h5A));  // Marker value
        emit(regInstr(isaPkg::SUB, 2'd1, 2'd0, 2'd0));
        emit(addrInstr(isaPkg::BNE, 1'b0, '0, 8'h0C));  // Zero set, falls through
        emit(addrInstr(isaPkg::ST, 1'b0, 2'd3, 8'hB0));
        emit(regInstr(isaPkg::INC, 2'd1, 2'd1, 2'd1));
        emit(addrInstr(isaPkg::BNE, 1'b0, '0, 8'h10));  // Zero clear, taken
        emit(addrInstr(isaPkg::ST, 1'b0, 2'd3, 8'hB1));
        emit(addrInstr(isaPkg::ST, 1'b0, 2'd0, 8'hB2));
        haltHere();
        expectWrite(8'hB0, 8'h5A);
        expectWrite(8'hB2, v);
        for (int a = 0; a <= 12; a += 2) begin
            expFetchQ.push_back(a);
        end
        expFetchQ.push_back(8'h10);
        expFetchQ.push_back(8'h12);
        finishTest();
    endtask

    task automatic nopTest();
        dataByte_t   a;
        dataByte_t   b;
        logic [11:0] junk;
        startTest();
        a = $urandom % 256;
        b = $urandom % 256;
        emit(addrInstr(isaPkg::LD, 1'b1, 2'd0, a));
        emit(addrInstr(isaPkg::LD, 1'b1, 2'd1, b));
        junk = $urandom % 4096;
        emit({4'hB, junk});
        junk = $urandom % 4096;
        emit({4'hC, junk});
        emit(addrInstr(isaPkg::ST, 1'b0, 2'd0, 8'hD0));
        emit(addrInstr(isaPkg::ST, 1'b0, 2'd1, 8'hD1));
        expectWrite(8'hD0, a);
        expectWrite(8'hD1, b);
        haltHere();
        expectStraight();
        finishTest();
    endtask

    initial begin
        rstN = 1'b0;
        void'($urandom(58793));
        resetTest();
        loadStoreTest();
        aluTest();
        aluTest();
        timingTest();
        bneTest();
        nopTest();
        $display("Error counts: data %0d, fetch address %0d, other %0d", dataErrors,
                 addrErrors, otherErrors);
        if (dataErrors + addrErrors + otherErrors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim/tbClock.sv ====
// Free-running clock that starts low, the period must be an even number of nanoseconds
`timescale 1ns/1ps
`default_nettype none

module tbClock #(
    parameter int PeriodNs = 10
) (
    output logic CLK
);

    initial begin
        CLK = 1'b0;
    end

    always #(PeriodNs / 2) CLK = ~CLK;  // Even duty cycle

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+include
hdl/isaPkg.sv
hdl/datapathPkg.sv
hdl/controlFsm.sv
hdl/programCounter.sv
hdl/registerFile.sv
hdl/alu.sv
hdl/cpuTop.sv
sim/tbClock.sv
sim/cpuTb.sv
